// ==== arduboy_host.f ====
+incdir+common
common/arduboy_pkg.sv
rom_loader/rom_write_decode.sv
rom_loader/program_rom.sv
source/video_cleanup.sv
audio/audio_clock_gen.sv
audio/i2s_serializer.sv
source/arduboy_host_top.sv
verif/tb_arduboy_host.sv

// ==== Makefile ====
# Verilator flow for the handheld host side

TB_TOP = tb_arduboy_host

.PHONY: lint sim clean

# lint the RTL top level
lint:
	verilator --lint-only --timing -f arduboy_host.f --top-module arduboy_host_top

# build and run the testbench, exit status carries pass or fail
sim:
	verilator --binary --timing -f arduboy_host.f --top-module $(TB_TOP) -o $(TB_TOP)
	./obj_dir/$(TB_TOP)

clean:
	rm -rf obj_dir

// ==== verif/tb_arduboy_host.sv ====
////////////////////////////////////////////////////////////
// testbench for the host-side top level
// ROM load, button map, video cleanup, MCLK and I2S checks
// with reference models and a per-cycle compare process
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "arduboy_consts.svh"

module tb_arduboy_host
  import arduboy_pkg::*;
();

  logic         clk_74a = 1'b0;
  logic         rst_n;
  bridge_addr_t bridge_addr;
  logic         bridge_wr;
  bridge_word_t bridge_wr_data;
  rom_addr_t    pgm_addr;
  rom_word_t    pgm_data;
  logic [15:0]  cont1_key;
  logic [5:0]   buttons;
  raster_in_t   raster;
  video_out_t   video;
  logic         buzzer1;
  logic         buzzer2;
  logic         audio_mclk;
  logic         audio_lrck;
  logic         audio_dac;

  // reference state
  logic [31:0] rng_state = 32'haa1b_1b80;
  rom_word_t   rom_model [`ARDU_ROM_DEPTH];
  logic [20:0] model_acc;
  logic        model_mclk;
  int unsigned mclk_toggles = 0;
  video_out_t  exp_video;
  logic        prev_hsync;
  logic        prev_vsync;

  arduboy_host_top u_dut (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .pgm_addr       (pgm_addr),
    .pgm_data       (pgm_data),
    .cont1_key      (cont1_key),
    .buttons        (buttons),
    .raster         (raster),
    .video          (video),
    .buzzer1        (buzzer1),
    .buzzer2        (buzzer2),
    .audio_mclk     (audio_mclk),
    .audio_lrck     (audio_lrck),
    .audio_dac      (audio_dac)
  );

  always #2 clk_74a = ~clk_74a;

  ////////////////////////////////////////////////////////////
  // reference functions
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // even index gets {b2,b3}, odd index gets {b0,b1}
  function automatic rom_word_t halfword_of(input bridge_word_t w, input logic odd);
    return odd ? {w[7:0], w[15:8]} : {w[23:16], w[31:24]};
  endfunction

  function automatic logic [5:0] button_map(input logic [15:0] key);
    return ~{key[5], key[4], key[0], key[1], key[2], key[3]};
  endfunction

  function automatic video_out_t video_rule(input raster_in_t r, input logic ph,
                                            input logic pv);
    video_out_t v;
    v.hs  = r.hsync & ~ph;
    v.vs  = r.vsync & ~pv;
    v.de  = ~(r.hblank | r.vblank);
    v.rgb = (v.de && r.pixel) ? `ARDU_RGB_WHITE : 24'd0;
    return v;
  endfunction

  function automatic logic [20:0] accum_next(input logic [20:0] acc);
    if (acc >= `ARDU_MCLK_MOD)
      return acc - `ARDU_MCLK_MOD + `ARDU_MCLK_STEP;
    return acc + `ARDU_MCLK_STEP;
  endfunction

  // top 16 bits of the buzzer mix
  function automatic logic [15:0] mixed_top(input logic b1, input logic b2);
    logic [31:0] s;
    s = (b1 ? 32'h3FFF_FFFF : 32'd0) + (b2 ? 32'h3FFF_FFFF : 32'd0);
    return s[31:16];
  endfunction

  ////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////
  task automatic fail_stop(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
      fail_stop($sformatf("Fail at %0t: %s = %h, expected %h", $realtime, name, got,
                          expected));
  endtask

  // models advance on the same edge as the DUT
  always @(posedge clk_74a or negedge rst_n)
  begin
    if (!rst_n)
    begin
      model_acc  = '0;
      model_mclk = 1'b0;
      exp_video  = '0;
      prev_hsync = 1'b0;
      prev_vsync = 1'b0;
    end
    else
    begin
      if (model_acc >= `ARDU_MCLK_MOD)
      begin
        model_mclk = ~model_mclk;
        mclk_toggles++;
      end
      model_acc  = accum_next(model_acc);
      exp_video  = video_rule(raster, prev_hsync, prev_vsync);
      prev_hsync = raster.hsync;
      prev_vsync = raster.vsync;
    end
  end

  // compare mid-cycle
  always @(negedge clk_74a)
  begin
    check_value("audio_mclk", 32'(audio_mclk), 32'(model_mclk));
    check_value("video.de", 32'(video.de), 32'(exp_video.de));
    check_value("video.hs", 32'(video.hs), 32'(exp_video.hs));
    check_value("video.vs", 32'(video.vs), 32'(exp_video.vs));
    check_value("video.rgb", 32'(video.rgb), 32'(exp_video.rgb));
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////
  task automatic next_cycle();
    @(posedge clk_74a);
    #0.5;
  endtask

  task automatic drive_write(input bridge_addr_t addr, input bridge_word_t data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    next_cycle();
    bridge_wr      = 1'b0;
  endtask

  task automatic write_rom_word(input logic [12:0] k, input bridge_word_t data);
    drive_write({`ARDU_ROM_WINDOW, 13'd0, k, 2'b00}, data);
    rom_model[{k, 1'b0}] = halfword_of(data, 1'b0);
    rom_model[{k, 1'b1}] = halfword_of(data, 1'b1);
  endtask

  // registered read, one cycle after the address
  task automatic read_and_check(input rom_addr_t idx);
    pgm_addr = idx;
    next_cycle();
    check_value("pgm_data", 32'(pgm_data), 32'(rom_model[idx]));
  endtask

  task automatic read_pair(input logic [12:0] k);
    read_and_check({k, 1'b0});
    read_and_check({k, 1'b1});
  endtask

  // polls lrck or mclk once per cycle until it rises
  task automatic wait_output_rise(input logic use_lrck, input int limit,
                                  input string what);
    logic prev;
    logic seen;
    int   n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < limit)
    begin
      prev = use_lrck ? audio_lrck : audio_mclk;
      next_cycle();
      seen = (use_lrck ? audio_lrck : audio_mclk) && !prev;
      n++;
    end
    if (!seen)
      fail_stop($sformatf("timeout while waiting for %s to rise", what));
  endtask

  // counts mclk rises up to the next lrck rise
  task automatic measure_frame(output int rises);
    logic prev_l;
    logic prev_m;
    logic seen;
    int   n;
    seen  = 1'b0;
    n     = 0;
    rises = 0;
    while (!seen && n < 4000)
    begin
      prev_l = audio_lrck;
      prev_m = audio_mclk;
      next_cycle();
      if (audio_mclk && !prev_m)
        rises++;
      seen = audio_lrck && !prev_l;
      n++;
    end
    if (!seen)
      fail_stop("timeout while waiting for audio_lrck to rise");
  endtask

  // one bit period is four mclk rises, sampled at the second
  task automatic sample_dac_bit(output logic v);
    wait_output_rise(1'b0, 20, "audio_mclk");
    wait_output_rise(1'b0, 20, "audio_mclk");
    v = audio_dac;
    wait_output_rise(1'b0, 20, "audio_mclk");
    wait_output_rise(1'b0, 20, "audio_mclk");
  endtask

  ////////////////////////////////////////////////////////////
  // test phases
  ////////////////////////////////////////////////////////////
  task automatic load_and_readback();
    logic [12:0] keys [64];
    logic [31:0] r;
    for (int i = 0; i < 64; i++)
    begin
      r       = next_rand();
      keys[i] = r[12:0];
      write_rom_word(keys[i], next_rand());
      // both halfwords land two edges later
      repeat (2) next_cycle();
      read_pair(keys[i]);
      r = next_rand();
      repeat (r[1:0]) next_cycle();
    end
    // later writes must not have touched earlier words
    for (int i = 0; i < 64; i++)
      read_pair(keys[i]);
  endtask

  task automatic ignored_writes();
    write_rom_word(13'h0456, 32'h1122_3344);
    repeat (2) next_cycle();
    write_rom_word(13'h0789, 32'h5566_7788);
    repeat (2) next_cycle();
    // back to back, the second strobe is dropped
    write_rom_word(13'h0123, 32'hA1B2_C3D4);
    drive_write({`ARDU_ROM_WINDOW, 13'd0, 13'h0456, 2'b00}, 32'hDEAD_BEEF);
    repeat (2) next_cycle();
    // outside the ROM window
    drive_write({4'h1, 13'd0, 13'h0789, 2'b00}, 32'hCAFE_F00D);
    repeat (3) next_cycle();
    read_pair(13'h0123);
    read_pair(13'h0456);
    read_pair(13'h0789);
  endtask

  task automatic button_test();
    logic [31:0] r;
    for (int i = 0; i < 32; i++)
    begin
      r         = next_rand();
      cont1_key = r[15:0];
      @(negedge clk_74a);
      check_value("buttons", 32'(buttons), 32'(button_map(cont1_key)));
      next_cycle();
    end
  endtask

  // random raster held 1 to 4 cycles, checked by the compare process
  task automatic video_test();
    logic [31:0] r;
    for (int i = 0; i < 120; i++)
    begin
      r      = next_rand();
      raster = r[4:0];
      repeat (int'(r[9:8]) + 1) next_cycle();
    end
    raster = '0;
  endtask

  task automatic i2s_check(input logic b1, input logic b2);
    logic [15:0] top;
    logic        bit_val;
    int          rises;
    buzzer1 = b1;
    buzzer2 = b2;
    top     = mixed_top(b1, b2);
    wait_output_rise(1'b1, 4000, "audio_lrck");
    // a frame is two slots of four mclk periods per bit
    measure_frame(rises);
    check_value("audio_lrck period", 32'(rises), 32'(2 * `ARDU_SLOT_BITS * 4));
    // I2S one-bit delay after the lrck edge
    sample_dac_bit(bit_val);
    check_value("audio_dac", 32'(bit_val), 32'd0);
    for (int n = 15; n >= 0; n--)
    begin
      sample_dac_bit(bit_val);
      check_value("audio_dac", 32'(bit_val), 32'(top[n]));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    rst_n          = 1'b0;
    bridge_addr    = '0;
    bridge_wr      = 1'b0;
    bridge_wr_data = '0;
    pgm_addr       = '0;
    cont1_key      = '0;
    raster         = '0;
    buzzer1        = 1'b0;
    buzzer2        = 1'b0;
    repeat (4) @(posedge clk_74a);
    #0.5;
    rst_n = 1'b1;

    load_and_readback();
    ignored_writes();
    button_test();
    video_test();
    i2s_check(1'b0, 1'b0);
    i2s_check(1'b1, 1'b0);
    i2s_check(1'b0, 1'b1);
    i2s_check(1'b1, 1'b1);

    if (mclk_toggles < 200)
      fail_stop("fewer than 200 mclk toggles were seen during the run");
    else
    begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== source/arduboy_host_top.sv ====
////////////////////////////////////////////////////////////
// host-side top level
// ROM loader, program port, button map, video cleanup and
// I2S audio output
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module arduboy_host_top
  import arduboy_pkg::*;
(
  input  wire          clk_74a,
  input  wire          rst_n,
  // bridge write strobe
  input  bridge_addr_t bridge_addr,
  input  wire          bridge_wr,
  input  bridge_word_t bridge_wr_data,
  // CPU fetch
  input  rom_addr_t    pgm_addr,
  output rom_word_t    pgm_data,
  // controls
  input  wire [15:0]   cont1_key,
  output wire [5:0]    buttons,
  // video
  input  raster_in_t   raster,
  output video_out_t   video,
  // audio
  input  wire          buzzer1,
  input  wire          buzzer2,
  output logic         audio_mclk,
  output logic         audio_lrck,
  output logic         audio_dac
);

  rom_write_t rom_wr;
  logic       bit_tick;

  ////////////////////////////////////////////////////////////
  // button map, CPU buttons are active low
  ////////////////////////////////////////////////////////////

  // right, left, down, up
  assign buttons[0] = ~cont1_key[3];
  assign buttons[1] = ~cont1_key[2];
  assign buttons[2] = ~cont1_key[1];
  assign buttons[3] = ~cont1_key[0];
  // A, B
  assign buttons[4] = ~cont1_key[4];
  assign buttons[5] = ~cont1_key[5];

  ////////////////////////////////////////////////////////////
  // program ROM
  ////////////////////////////////////////////////////////////
  rom_write_decode u_rom_write_decode (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .rom_wr         (rom_wr)
  );

  program_rom u_program_rom (
    .clk_74a  (clk_74a),
    .rst_n    (rst_n),
    .rom_wr   (rom_wr),
    .pgm_addr (pgm_addr),
    .pgm_data (pgm_data)
  );

  // video and audio outputs
  video_cleanup u_video_cleanup (
    .clk_74a (clk_74a),
    .rst_n   (rst_n),
    .raster  (raster),
    .video   (video)
  );

  audio_clock_gen u_audio_clock_gen (
    .clk_74a  (clk_74a),
    .rst_n    (rst_n),
    .mclk     (audio_mclk),
    .bit_tick (bit_tick)
  );

  i2s_serializer u_i2s_serializer (
    .clk_74a  (clk_74a),
    .rst_n    (rst_n),
    .bit_tick (bit_tick),
    .buzzer1  (buzzer1),
    .buzzer2  (buzzer2),
    .lrck     (audio_lrck),
    .dac      (audio_dac)
  );

endmodule

`default_nettype wire

// ==== audio/i2s_serializer.sv ====
////////////////////////////////////////////////////////////
// I2S serializer for the two buzzers
// mixes to one sample, 16 active bits per 32-bit slot
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "arduboy_consts.svh"

module i2s_serializer
  import arduboy_pkg::*;
(
  input  wire  clk_74a,
  input  wire  rst_n,
  input  wire  bit_tick,
  input  wire  buzzer1,
  input  wire  buzzer2,
  output logic lrck,
  output logic dac
);

  sample_t     sample;
  sample_t     shifter;
  slot_count_t slot_cnt;

  ////////////////////////////////////////////////////////////
  // mix
  ////////////////////////////////////////////////////////////

  // each term stays below 2^30, so the sum keeps the sign bit clear
  assign sample = {2'b00, {30{buzzer1}}} + {2'b00, {30{buzzer2}}};

  ////////////////////////////////////////////////////////////
  // shifter, one step per SCLK falling edge
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_74a or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shifter  <= '0;
      slot_cnt <= '0;
      lrck     <= 1'b0;
      dac      <= 1'b0;
    end
    else if (bit_tick)
    begin
      dac      <= shifter[31];
      slot_cnt <= slot_cnt + 5'd1;

      if (slot_cnt == 5'(`ARDU_SLOT_BITS - 1))
      begin
        // channel switch
        lrck <= ~lrck;
        // new sample once per frame, at the lrck rise
        if (!lrck)
          shifter <= sample;
      end
      else if (slot_cnt < 5'(`ARDU_ACTIVE_BITS))
      begin
        shifter <= {shifter[30:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// ==== audio/audio_clock_gen.sv ====
////////////////////////////////////////////////////////////
// audio clocks from clk_74a
// fractional MCLK, SCLK = MCLK / 4, bit tick on SCLK fall
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "arduboy_consts.svh"

module audio_clock_gen (
  input  wire  clk_74a,
  input  wire  rst_n,
  output logic mclk,
  output logic bit_tick
);

  logic [20:0] accum;
  logic        mclk_prev;
  logic        mclk_rise;
  logic [1:0]  mclk_div;
  logic        sclk;

  assign mclk_rise = mclk & ~mclk_prev;
  assign sclk      = mclk_div[1];

  always_ff @(posedge clk_74a or negedge rst_n)
  begin
    if (!rst_n)
    begin
      accum     <= '0;
      mclk      <= 1'b0;
      mclk_prev <= 1'b0;
      mclk_div  <= '0;
      bit_tick  <= 1'b0;
    end
    else
    begin
      // 12.288 MHz average, toggled on each wrap
      if (accum >= `ARDU_MCLK_MOD)
      begin
        accum <= accum - `ARDU_MCLK_MOD + `ARDU_MCLK_STEP;
        mclk  <= ~mclk;
      end
      else
        accum <= accum + `ARDU_MCLK_STEP;

      mclk_prev <= mclk;
      if (mclk_rise)
        mclk_div <= mclk_div + 2'd1;

      // divider going 3 -> 0 is the SCLK falling edge
      bit_tick <= mclk_rise & sclk & mclk_div[0];
    end
  end

endmodule

`default_nettype wire

// ==== source/video_cleanup.sv ====
////////////////////////////////////////////////////////////
// raster cleanup for the scaler
// single-cycle hs/vs pulses, data enable, mono pixel colour
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "arduboy_consts.svh"

module video_cleanup
  import arduboy_pkg::*;
(
  input  wire        clk_74a,
  input  wire        rst_n,
  input  raster_in_t raster,
  output video_out_t video
);

  logic hs_prev;
  logic vs_prev;
  logic de_next;
  rgb_t rgb_next;

  // active area only outside both blanking intervals
  assign de_next = ~(raster.hblank | raster.vblank);

  // scaler wants black whenever de is low
  assign rgb_next = (de_next && raster.pixel) ? `ARDU_RGB_WHITE : '0;

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_74a or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      video.de  <= 1'b0;
      video.hs  <= 1'b0;
      video.vs  <= 1'b0;
      video.rgb <= '0;
    end
    else
    begin
      hs_prev <= raster.hsync;
      vs_prev <= raster.vsync;

      // rising edge of the converter syncs, one clock wide
      video.hs <= ~hs_prev & raster.hsync;
      video.vs <= ~vs_prev & raster.vsync;

      video.de  <= de_next;
      video.rgb <= rgb_next;
    end
  end

endmodule

`default_nettype wire

// ==== rom_loader/program_rom.sv ====
////////////////////////////////////////////////////////////
// program ROM, 16-bit halfwords
// bridge write port and registered CPU fetch port
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "arduboy_consts.svh"

module program_rom
  import arduboy_pkg::*;
(
  input  wire        clk_74a,
  input  wire        rst_n,
  input  rom_write_t rom_wr,
  input  rom_addr_t  pgm_addr,
  output rom_word_t  pgm_data
);

  rom_word_t mem [`ARDU_ROM_DEPTH];

  // loader side
  always_ff @(posedge clk_74a)
  begin
    if (rom_wr.valid)
      mem[rom_wr.addr] <= rom_wr.data;
  end

  // fetch side
  // a same-cycle write to pgm_addr is not seen until the next read
  always_ff @(posedge clk_74a or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pgm_data <= '0;
    end
    else
    begin
      pgm_data <= mem[pgm_addr];
    end
  end

endmodule

`default_nettype wire

// ==== rom_loader/rom_write_decode.sv ====
////////////////////////////////////////////////////////////
// bridge write decoder for the program ROM
// splits each big-endian 32-bit word into two halfword
// writes on consecutive cycles
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "arduboy_consts.svh"

module rom_write_decode
  import arduboy_pkg::*;
(
  input  wire          clk_74a,
  input  wire          rst_n,
  input  bridge_addr_t bridge_addr,
  input  wire          bridge_wr,
  input  bridge_word_t bridge_wr_data,
  output rom_write_t   rom_wr
);

  load_state_t state;
  logic        rom_hit;

  // registered write port
  logic      wr_valid;
  rom_addr_t wr_addr;
  rom_word_t wr_data;

  // second halfword, issued one cycle later
  rom_addr_t hold_addr;
  rom_word_t hold_data;

  assign rom_hit = bridge_wr && (bridge_addr[31:28] == `ARDU_ROM_WINDOW);

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_74a or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= LOAD_LOW;
      wr_valid <= 1'b0;
    end
    else
    begin
      // new strobes are dropped while the high half is pending
      wr_valid <= (state == LOAD_HIGH) || rom_hit;
      if (state == LOAD_HIGH)
        state <= LOAD_LOW;
      else if (rom_hit)
        state <= LOAD_HIGH;
    end
  end

  ////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_74a)
  begin
    if (state == LOAD_HIGH)
    begin
      wr_addr <= hold_addr;
      wr_data <= hold_data;
    end
    else if (rom_hit)
    begin
      // even index, bytes b2 b3 swapped into little-endian order
      wr_addr   <= {bridge_addr[14:2], 1'b0};
      wr_data   <= {bridge_wr_data[23:16], bridge_wr_data[31:24]};
      hold_addr <= {bridge_addr[14:2], 1'b1};
      hold_data <= {bridge_wr_data[7:0], bridge_wr_data[15:8]};
    end
  end

  assign rom_wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

// ==== common/arduboy_pkg.sv ====
////////////////////////////////////////////////////////////
// shared types for the host side
// bus widths, ROM write and video structs, loader states
////////////////////////////////////////////////////////////
`default_nettype none

package arduboy_pkg;

  ////////////////////////////////////////////////////////////
  // plain widths
  ////////////////////////////////////////////////////////////

  // bridge bus, synchronous to clk_74a
  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_word_t;

  // program memory, one entry per CPU instruction halfword
  typedef logic [13:0] rom_addr_t;
  typedef logic [15:0] rom_word_t;

  typedef logic [23:0] rgb_t;

  // audio
  typedef logic [31:0] sample_t;
  typedef logic [4:0]  slot_count_t;

  ////////////////////////////////////////////////////////////
  // grouped signals
  ////////////////////////////////////////////////////////////

  // one halfword write into the program ROM
  typedef struct packed {
    logic      valid;
    rom_addr_t addr;
    rom_word_t data;
  } rom_write_t;

  // raw raster from the OLED converter
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic hblank;
    logic vblank;
    logic pixel;
  } raster_in_t;

  // scaler-ready video
  typedef struct packed {
    logic de;
    logic hs;
    logic vs;
    rgb_t rgb;
  } video_out_t;

  // ROM loader, second halfword pending or not
  typedef enum logic [0:0] {
    LOAD_LOW  = 1'b0,
    LOAD_HIGH = 1'b1
  } load_state_t;

endpackage

`default_nettype wire

// ==== common/arduboy_consts.svh ====
////////////////////////////////////////////////////////////
// host-side constants for the handheld core
// ROM window and depth, audio clock ratio, I2S slot shape
// and the lit pixel colour
////////////////////////////////////////////////////////////
`ifndef ARDUBOY_CONSTS_SVH
`define ARDUBOY_CONSTS_SVH

// bridge address nibble [31:28] that selects the program ROM
`define ARDU_ROM_WINDOW 4'h0

// program ROM size in 16-bit halfwords (32 KiB)
`define ARDU_ROM_DEPTH 16384

// fractional accumulator for MCLK from 74.25 MHz
// step / mod = 2 * 12.288 / 74.25
`define ARDU_MCLK_STEP 21'd245760
`define ARDU_MCLK_MOD 21'd742500

// I2S framing
`define ARDU_SLOT_BITS 32
// only the first 16 bits of a slot carry data
`define ARDU_ACTIVE_BITS 16

// OLED pixel on
`define ARDU_RGB_WHITE 24'hFF_FFFF

`endif
